/* rtl/rs5_pkg.sv */
package rs5_pkg;

    //////////////////////////////
    // Widths and constants
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Read-only counter CSRs
    localparam logic [11:0] CSR_CYCLE   = 12'hC00;
    localparam logic [11:0] CSR_INSTRET = 12'hC02;

    // Major opcodes of the kept RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Operation kind, picks the datapath route
    typedef enum logic [3:0] {
        OP_ALU, OP_ALUI, OP_LUI, OP_BRANCH, OP_JAL,
        OP_LOAD, OP_STORE, OP_CSR, OP_ILLEGAL
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    // Per-instruction steps
    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
    } core_state_e;

    typedef struct packed {
        op_e        op;
        alu_op_e    alu_op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        // Branch condition or load/store width
        logic [2:0] funct3;
        // High for instret, low for cycle
        logic       csr_instret;
    } decoded_t;

    typedef struct packed {
        word_t      addr;
        logic [3:0] wstrb;
        word_t      wdata;
        logic       read_en;
    } mem_req_t;

    typedef struct packed {
        logic       en;
        reg_addr_t  rd;
        word_t      data;
    } reg_write_t;

endpackage

/* rtl/core_control.sv */
module core_control (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stall_i,
    input  rs5_pkg::decoded_t decoded_i,
    output logic              latch_instr_o,
    output logic              exec_o,
    output logic              mem_o,
    output logic              load_wb_o,
    output logic              retire_o
);

    rs5_pkg::core_state_e state_q;
    rs5_pkg::core_state_e state_d;
    logic                 step;
    logic                 is_load;
    logic                 is_mem;

    // One state per unstalled cycle
    assign step = !stall_i;

    // Route after EXECUTE
    assign is_load = decoded_i.op == rs5_pkg::OP_LOAD;
    assign is_mem  = is_load || (decoded_i.op == rs5_pkg::OP_STORE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rs5_pkg::FETCH: begin
                state_d = rs5_pkg::DECODE;
            end
            rs5_pkg::DECODE: begin
                state_d = rs5_pkg::EXECUTE;
            end
            // Loads and stores visit memory, the rest are done
            rs5_pkg::EXECUTE: begin
                state_d = is_mem ? rs5_pkg::MEMORY : rs5_pkg::FETCH;
            end
            // Only loads need a writeback step
            rs5_pkg::MEMORY: begin
                state_d = is_load ? rs5_pkg::WRITEBACK : rs5_pkg::FETCH;
            end
            default: begin
                state_d = rs5_pkg::FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= rs5_pkg::FETCH;
        end else if (step) begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Step strobes
    //////////////////////////////

    // Instruction word arrives during DECODE
    assign latch_instr_o = step && (state_q == rs5_pkg::DECODE);
    assign exec_o        = step && (state_q == rs5_pkg::EXECUTE);
    // Request registered at end of EXECUTE
    assign mem_o         = exec_o && is_mem;
    assign load_wb_o     = step && (state_q == rs5_pkg::WRITEBACK);

    // Last cycle, illegal ops fall through as no-ops
    assign retire_o = step && (((state_q == rs5_pkg::EXECUTE) && !is_mem)
                            || ((state_q == rs5_pkg::MEMORY) && !is_load)
                            || (state_q == rs5_pkg::WRITEBACK));

endmodule

/* rtl/perf_counters.sv */
module perf_counters (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           retire_i,
    input  logic           csr_instret_i,
    output rs5_pkg::word_t csr_value_o
);

    rs5_pkg::word_t cycle_q;
    rs5_pkg::word_t instret_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            // Stalled cycles are not counted
            if (!stall_i) begin
                cycle_q <= cycle_q + 32'd1;
            end
            if (retire_i) begin
                instret_q <= instret_q + 32'd1;
            end
        end
    end

    // Read in EXECUTE, before the reading instruction retires
    assign csr_value_o = csr_instret_i ? instret_q : cycle_q;

endmodule

/* rtl/decoder.sv */
module decoder (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              latch_i,
    input  rs5_pkg::word_t    instruction_i,
    output rs5_pkg::decoded_t decoded_o
);

    rs5_pkg::word_t instr_q;
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic [11:0]    csr_addr;
    rs5_pkg::word_t imm_i;
    rs5_pkg::word_t imm_s;
    rs5_pkg::word_t imm_b;
    rs5_pkg::word_t imm_j;
    rs5_pkg::word_t imm_u;

    // Instruction register, all-zero word decodes as illegal
    always_ff @(posedge clk) begin
        if (reset_i) begin
            instr_q <= '0;
        end else if (latch_i) begin
            instr_q <= instruction_i;
        end
    end

    assign opcode   = instr_q[6:0];
    assign funct3   = instr_q[14:12];
    assign funct7   = instr_q[31:25];
    assign csr_addr = instr_q[31:20];

    // Immediate formats
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};
    assign imm_u = {instr_q[31:12], 12'h000};

    always_comb begin
        decoded_o.op          = rs5_pkg::OP_ILLEGAL;
        decoded_o.alu_op      = rs5_pkg::ALU_ADD;
        decoded_o.rd          = instr_q[11:7];
        decoded_o.rs1         = instr_q[19:15];
        decoded_o.rs2         = instr_q[24:20];
        decoded_o.imm         = imm_i;
        decoded_o.funct3      = funct3;
        decoded_o.csr_instret = csr_addr == rs5_pkg::CSR_INSTRET;
        case (opcode)
            rs5_pkg::OPC_OP: begin
                decoded_o.op = rs5_pkg::OP_ALU;
                case ({funct7, funct3})
                    10'b0000000_000: decoded_o.alu_op = rs5_pkg::ALU_ADD;
                    10'b0100000_000: decoded_o.alu_op = rs5_pkg::ALU_SUB;
                    10'b0000000_111: decoded_o.alu_op = rs5_pkg::ALU_AND;
                    10'b0000000_110: decoded_o.alu_op = rs5_pkg::ALU_OR;
                    10'b0000000_100: decoded_o.alu_op = rs5_pkg::ALU_XOR;
                    10'b0000000_010: decoded_o.alu_op = rs5_pkg::ALU_SLT;
                    default:         decoded_o.op     = rs5_pkg::OP_ILLEGAL;
                endcase
            end
            // ADDI only
            rs5_pkg::OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    decoded_o.op = rs5_pkg::OP_ALUI;
                end
            end
            rs5_pkg::OPC_LUI: begin
                decoded_o.op  = rs5_pkg::OP_LUI;
                decoded_o.imm = imm_u;
            end
            // BEQ, BNE
            rs5_pkg::OPC_BRANCH: begin
                decoded_o.imm = imm_b;
                if (funct3[2:1] == 2'b00) begin
                    decoded_o.op = rs5_pkg::OP_BRANCH;
                end
            end
            rs5_pkg::OPC_JAL: begin
                decoded_o.op  = rs5_pkg::OP_JAL;
                decoded_o.imm = imm_j;
            end
            // LB, LW, LBU
            rs5_pkg::OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b010, 3'b100}) begin
                    decoded_o.op = rs5_pkg::OP_LOAD;
                end
            end
            // SB, SW
            rs5_pkg::OPC_STORE: begin
                decoded_o.imm = imm_s;
                if (funct3 inside {3'b000, 3'b010}) begin
                    decoded_o.op = rs5_pkg::OP_STORE;
                end
            end
            // CSRRS rd, counter, x0
            rs5_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'b010 && instr_q[19:15] == 5'd0
                        && (csr_addr == rs5_pkg::CSR_CYCLE
                        || csr_addr == rs5_pkg::CSR_INSTRET)) begin
                    decoded_o.op = rs5_pkg::OP_CSR;
                end
            end
            default: begin
                decoded_o.op = rs5_pkg::OP_ILLEGAL;
            end
        endcase
    end

endmodule

/* rtl/regbank.sv */
module regbank (
    input  logic                clk,
    input  logic                reset_i,
    input  rs5_pkg::reg_addr_t  rs1_i,
    input  rs5_pkg::reg_addr_t  rs2_i,
    input  rs5_pkg::reg_write_t write_i,
    output rs5_pkg::word_t      data1_o,
    output rs5_pkg::word_t      data2_o
);

    // x1..x31, x0 has no storage
    rs5_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i.en && (write_i.rd != 5'd0)) begin
            regs[write_i.rd] <= write_i.data;
        end
    end

    // Combinational reads
    assign data1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* rtl/execute_unit.sv */
module execute_unit (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              exec_i,
    input  logic              retire_i,
    input  rs5_pkg::decoded_t decoded_i,
    input  rs5_pkg::word_t    rs1_data_i,
    input  rs5_pkg::word_t    rs2_data_i,
    input  rs5_pkg::word_t    csr_value_i,
    output rs5_pkg::word_t    pc_o,
    output rs5_pkg::word_t    result_o,
    output rs5_pkg::word_t    store_data_o
);

    rs5_pkg::word_t pc_q;
    rs5_pkg::word_t next_pc_q;
    rs5_pkg::word_t next_pc;
    rs5_pkg::word_t pc_plus4;
    rs5_pkg::word_t alu_b;
    rs5_pkg::word_t alu_res;
    logic           taken;

    // Register operand only for R-type
    assign alu_b = (decoded_i.op == rs5_pkg::OP_ALU) ? rs2_data_i : decoded_i.imm;

    always_comb begin
        case (decoded_i.alu_op)
            rs5_pkg::ALU_SUB: alu_res = rs1_data_i - alu_b;
            rs5_pkg::ALU_AND: alu_res = rs1_data_i & alu_b;
            rs5_pkg::ALU_OR:  alu_res = rs1_data_i | alu_b;
            rs5_pkg::ALU_XOR: alu_res = rs1_data_i ^ alu_b;
            rs5_pkg::ALU_SLT: alu_res = {31'd0, $signed(rs1_data_i) < $signed(alu_b)};
            default:          alu_res = rs1_data_i + alu_b;
        endcase
    end

    assign pc_plus4 = pc_q + 32'd4;

    // Loads and stores take the ADD path, result is the address
    always_comb begin
        case (decoded_i.op)
            rs5_pkg::OP_LUI: result_o = decoded_i.imm;
            rs5_pkg::OP_JAL: result_o = pc_plus4;
            rs5_pkg::OP_CSR: result_o = csr_value_i;
            default:         result_o = alu_res;
        endcase
    end

    ////////////////////////////////
    // Next PC
    ////////////////////////////////

    // funct3[0] inverts the compare for BNE
    assign taken = (decoded_i.op == rs5_pkg::OP_JAL)
                || ((decoded_i.op == rs5_pkg::OP_BRANCH)
                && ((rs1_data_i == rs2_data_i) ^ decoded_i.funct3[0]));
    assign next_pc = taken ? pc_q + decoded_i.imm : pc_plus4;

    // Held for instructions that retire after EXECUTE
    always_ff @(posedge clk) begin
        if (exec_i) begin
            next_pc_q <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= rs5_pkg::RESET_PC;
        end else if (retire_i) begin
            pc_q <= exec_i ? next_pc : next_pc_q;
        end
    end

    assign pc_o         = pc_q;
    assign store_data_o = rs2_data_i;

endmodule

/* rtl/mem_retire.sv */
module mem_retire (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                stall_i,
    input  logic                mem_i,
    input  logic                load_wb_i,
    input  logic                retire_i,
    input  rs5_pkg::decoded_t   decoded_i,
    input  rs5_pkg::word_t      result_i,
    input  rs5_pkg::word_t      store_data_i,
    input  rs5_pkg::word_t      mem_data_i,
    output rs5_pkg::mem_req_t   mem_req_o,
    output rs5_pkg::reg_write_t reg_write_o
);

    logic           read_en_q;
    logic [3:0]     wstrb_q;
    rs5_pkg::word_t addr_q;
    rs5_pkg::word_t wdata_q;
    logic           is_store;
    logic           is_byte;
    logic [3:0]     store_strb;
    rs5_pkg::word_t lane_word;
    rs5_pkg::word_t load_data;
    logic           has_rd;

    assign is_store = decoded_i.op == rs5_pkg::OP_STORE;
    assign is_byte  = decoded_i.funct3[1:0] == 2'b00;
    // SB hits one lane picked by the low address bits
    assign store_strb = is_byte ? 4'b0001 << result_i[1:0] : 4'b1111;

    // Request control, live for the MEMORY cycle only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            read_en_q <= 1'b0;
            wstrb_q   <= 4'b0000;
        end else if (mem_i) begin
            read_en_q <= decoded_i.op == rs5_pkg::OP_LOAD;
            wstrb_q   <= is_store ? store_strb : 4'b0000;
        end else if (!stall_i) begin
            read_en_q <= 1'b0;
            wstrb_q   <= 4'b0000;
        end
    end

    // Address kept for load lane select in WRITEBACK
    always_ff @(posedge clk) begin
        if (mem_i) begin
            addr_q  <= result_i;
            wdata_q <= is_byte ? {4{store_data_i[7:0]}} : store_data_i;
        end
    end

    assign mem_req_o = '{addr: addr_q, wstrb: wstrb_q, wdata: wdata_q, read_en: read_en_q};

    // Byte lane down to bits 7:0
    assign lane_word = mem_data_i >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (decoded_i.funct3)
            3'b000:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            3'b100:  load_data = {24'd0, lane_word[7:0]};
            default: load_data = mem_data_i;
        endcase
    end

    // Ops that write rd
    assign has_rd = decoded_i.op inside {rs5_pkg::OP_ALU, rs5_pkg::OP_ALUI, rs5_pkg::OP_LUI,
                                         rs5_pkg::OP_JAL, rs5_pkg::OP_LOAD, rs5_pkg::OP_CSR};

    assign reg_write_o = '{en:   retire_i && has_rd,
                           rd:   decoded_i.rd,
                           data: load_wb_i ? load_data : result_i};

endmodule

/* rtl/rs5_core.sv */
module rs5_core (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           stall_i,

    input  rs5_pkg::word_t instruction_i,
    input  rs5_pkg::word_t mem_data_i,

    output rs5_pkg::word_t instruction_address_o,
    output logic           mem_operation_enable_o,
    output logic [3:0]     mem_write_enable_o,
    output rs5_pkg::word_t mem_address_o,
    output rs5_pkg::word_t mem_data_o
);

    //////////////////////////////
    // Internal wiring
    //////////////////////////////

    // Step strobes
    logic                latch_instr;
    logic                exec;
    logic                mem;
    logic                load_wb;
    logic                retire;

    rs5_pkg::decoded_t   decoded;
    rs5_pkg::word_t      rs1_data;
    rs5_pkg::word_t      rs2_data;
    rs5_pkg::word_t      csr_value;
    rs5_pkg::word_t      pc;
    rs5_pkg::word_t      result;
    rs5_pkg::word_t      store_data;
    rs5_pkg::mem_req_t   mem_req;
    rs5_pkg::reg_write_t reg_write;

    //////////////////////////////
    // Sequencing and counters
    //////////////////////////////

    core_control i_control (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .decoded_i     (decoded),
        .latch_instr_o (latch_instr),
        .exec_o        (exec),
        .mem_o         (mem),
        .load_wb_o     (load_wb),
        .retire_o      (retire)
    );

    perf_counters i_counters (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .retire_i      (retire),
        .csr_instret_i (decoded.csr_instret),
        .csr_value_o   (csr_value)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    decoder i_decoder (
        .clk           (clk),
        .reset_i       (reset_i),
        .latch_i       (latch_instr),
        .instruction_i (instruction_i),
        .decoded_o     (decoded)
    );

    regbank i_regbank (
        .clk     (clk),
        .reset_i (reset_i),
        .rs1_i   (decoded.rs1),
        .rs2_i   (decoded.rs2),
        .write_i (reg_write),
        .data1_o (rs1_data),
        .data2_o (rs2_data)
    );

    execute_unit i_execute (
        .clk          (clk),
        .reset_i      (reset_i),
        .exec_i       (exec),
        .retire_i     (retire),
        .decoded_i    (decoded),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .csr_value_i  (csr_value),
        .pc_o         (pc),
        .result_o     (result),
        .store_data_o (store_data)
    );

    mem_retire i_mem_retire (
        .clk          (clk),
        .reset_i      (reset_i),
        .stall_i      (stall_i),
        .mem_i        (mem),
        .load_wb_i    (load_wb),
        .retire_i     (retire),
        .decoded_i    (decoded),
        .result_i     (result),
        .store_data_i (store_data),
        .mem_data_i   (mem_data_i),
        .mem_req_o    (mem_req),
        .reg_write_o  (reg_write)
    );

    // Flat memory ports
    assign instruction_address_o  = pc;
    assign mem_operation_enable_o = mem_req.read_en || (mem_req.wstrb != 4'b0000);
    assign mem_write_enable_o     = mem_req.wstrb;
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

/* bench/rs5_mem_model.sv */
module rs5_mem_model (
    input  logic              clk,
    input  rs5_pkg::word_t    instr_addr_i,
    output rs5_pkg::word_t    instr_o,
    input  rs5_pkg::mem_req_t req_i,
    output rs5_pkg::word_t    rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 KiB, word organized, byte addressed
    rs5_pkg::word_t mem [0:1023];
    logic [9:0]     data_idx;

    assign data_idx = req_i.addr[11:2];

    initial begin
        instr_o = '0;
        rdata_o = '0;
    end

    //////////////////////////////
    // Instruction side
    //////////////////////////////

    // Word for the PC shows up one cycle later
    always @(posedge clk) begin
        instr_o <= mem[instr_addr_i[11:2]];
    end

    //////////////////////////////
    // Data side
    //////////////////////////////

    // Read data one cycle after read enable, held otherwise
    always @(posedge clk) begin
        if (req_i.read_en) begin
            rdata_o <= mem[data_idx];
        end
        // Byte lanes under the strobes
        for (int b = 0; b < 4; b++) begin
            if (req_i.wstrb[b]) begin
                mem[data_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
    end

endmodule

/* bench/tb_rs5_core.sv */
module tb_rs5_core;

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////
    // DUT and memory wiring
    //////////////////////////////

    logic              clk;
    logic              reset;
    logic              stall;
    rs5_pkg::word_t    instruction;
    rs5_pkg::word_t    mem_rdata;
    rs5_pkg::word_t    instruction_address;
    logic              mem_operation_enable;
    logic [3:0]        mem_write_enable;
    rs5_pkg::word_t    mem_address;
    rs5_pkg::word_t    mem_wdata;
    rs5_pkg::mem_req_t data_req;

    // Expected stores in program order
    rs5_pkg::mem_req_t expected [$];
    rs5_pkg::mem_req_t held_req;
    logic              held            = 1'b0;
    logic              final_seen      = 1'b0;
    logic              stimulus_loaded = 1'b0;
    int                store_idx       = 0;
    int                mismatch_errors = 0;
    int                other_errors    = 0;
    longint            watchdog_ns     = 0;
    integer            seed;

    rs5_core i_rs5_core (
        .clk                    (clk),
        .reset_i                (reset),
        .stall_i                (stall),
        .instruction_i          (instruction),
        .mem_data_i             (mem_rdata),
        .instruction_address_o  (instruction_address),
        .mem_operation_enable_o (mem_operation_enable),
        .mem_write_enable_o     (mem_write_enable),
        .mem_address_o          (mem_address),
        .mem_data_o             (mem_wdata)
    );

    // Flat data ports regrouped for the model
    assign data_req = '{addr:    mem_address,
                        wstrb:   mem_write_enable,
                        wdata:   mem_wdata,
                        read_en: mem_operation_enable && (mem_write_enable == 4'b0000)};

    rs5_mem_model i_mem_model (
        .clk          (clk),
        .instr_addr_i (instruction_address),
        .instr_o      (instruction),
        .req_i        (data_req),
        .rdata_o      (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus file
    //////////////////////////////

    task automatic load_stimulus();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      addr;
        logic [31:0]      word;
        logic [3:0]       strb;
        logic [8*128-1:0] rest;
        logic             done;
        fd = $fopen("bench/rs5_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/rs5_stimulus.txt");
            other_errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    $display("Stimulus file ends without an E line");
                    other_errors++;
                    done = 1'b1;
                end else begin
                    case (kind)
                        "#": code = $fgets(rest, fd);
                        // Program and data words share one memory
                        "P", "D": begin
                            code = $fscanf(fd, "%h %h", addr, word);
                            i_mem_model.mem[addr[11:2]] = word;
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %h %h", addr, strb, word);
                            expected.push_back('{addr: addr, wstrb: strb, wdata: word,
                                                 read_en: 1'b0});
                        end
                        "E": done = 1'b1;
                        default: begin
                            $display("Unknown line type %c in stimulus file", kind);
                            other_errors++;
                            done = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
            // Generous per-store budget, 4 ns per cycle
            watchdog_ns     = (expected.size() + 1) * 400 * 4;
            stimulus_loaded = (other_errors == 0) && (expected.size() > 0);
        end
    endtask

    //////////////////////////////
    // Store checking
    //////////////////////////////

    task automatic check_store(input rs5_pkg::mem_req_t got);
        rs5_pkg::mem_req_t want;
        if (store_idx >= expected.size()) begin
            $display("Extra store to address %h after all expected stores", got.addr);
            other_errors++;
        end else begin
            want = expected[store_idx];
            if (got.addr !== want.addr) begin
                $display("MISMATCH mem_address_o: got %h, expected %h", got.addr, want.addr);
                mismatch_errors++;
            end
            if (got.wstrb !== want.wstrb) begin
                $display("MISMATCH mem_write_enable_o: got %h, expected %h",
                         got.wstrb, want.wstrb);
                mismatch_errors++;
            end
            if (got.wdata !== want.wdata) begin
                $display("MISMATCH mem_data_o: got %h, expected %h", got.wdata, want.wdata);
                mismatch_errors++;
            end
            store_idx++;
        end
        // Last store of the program
        if (got.addr == 32'h0000_0FFC) begin
            final_seen = 1'b1;
        end
    endtask

    // A store counts on its unstalled edge, held copies must not change
    always @(posedge clk) begin
        if (!reset && mem_operation_enable && (mem_write_enable != 4'b0000)) begin
            if (held && (data_req !== held_req)) begin
                $display("MISMATCH data_req while stalled: got %h, expected %h",
                         data_req, held_req);
                mismatch_errors++;
            end
            if (stall) begin
                held     = 1'b1;
                held_req = data_req;
            end else begin
                held = 1'b0;
                check_store(data_req);
            end
        end else if (held) begin
            $display("Store to address %h vanished during a stall", held_req.addr);
            other_errors++;
            held = 1'b0;
        end
    end

    // PC at the reset address and no memory request while in reset
    task automatic check_reset_state();
        if (instruction_address !== 32'h0000_0000) begin
            $display("MISMATCH instruction_address_o: got %h, expected %h",
                     instruction_address, 32'h0000_0000);
            mismatch_errors++;
        end
        if (mem_operation_enable !== 1'b0) begin
            $display("MISMATCH mem_operation_enable_o: got %h, expected %h",
                     mem_operation_enable, 1'b0);
            mismatch_errors++;
        end
        if (mem_write_enable !== 4'h0) begin
            $display("MISMATCH mem_write_enable_o: got %h, expected %h",
                     mem_write_enable, 4'h0);
            mismatch_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Stores checked %0d of %0d, mismatches %0d, other errors %0d",
                 store_idx, expected.size(), mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main_flow
        seed  = 32'hba045a73;
        reset = 1'b1;
        stall = 1'b0;
        // Fill tied to the byte address so stray reads stand out
        for (int i = 0; i < 1024; i++) begin
            i_mem_model.mem[i] = 32'hA5C3_0000 | (i << 2);
        end
        load_stimulus();
        if (!stimulus_loaded) begin
            finish_run();
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            check_reset_state();
            reset = 1'b0;
            // Back-pressure one cycle in four
            while (!final_seen) begin
                @(negedge clk);
                stall = (($random(seed) & 3) == 0);
            end
            if (store_idx != expected.size()) begin
                $display("Final store came with %0d expected stores still missing",
                         expected.size() - store_idx);
                other_errors++;
            end
            finish_run();
        end
    end

    initial begin : watchdog
        wait (stimulus_loaded);
        #(watchdog_ns);
        $display("Watchdog fired, run timed out before final store");
        other_errors++;
        finish_run();
    end

endmodule

/* rs5_core.f */
rtl/rs5_pkg.sv
rtl/core_control.sv
rtl/perf_counters.sv
rtl/decoder.sv
rtl/regbank.sv
rtl/execute_unit.sv
rtl/mem_retire.sv
rtl/rs5_core.sv
bench/rs5_mem_model.sv
bench/tb_rs5_core.sv

/* bench/rs5_stimulus.txt */
# P addr word: program word, D addr word: initial data word
# S addr strobes data: expected store in order, E: end of file
# ALU, ALUI and LUI, results stored with SW
P 000 06400093
P 004 FF900113
P 008 002081B3
P 00C 40110233
P 010 001122B3
P 014 0020A333
P 018 F0F0F3B7
P 01C 0023C433
P 020 0023F4B3
P 024 0070E533
P 028 40302023
P 02C 40402223
P 030 40502423
P 034 40602623
P 038 40802823
P 03C 40902A23
P 040 40A02C23
# Branch and jump markers accumulate in x11
P 044 00108463
P 048 00158593
P 04C 00109463
P 050 01058593
P 054 00208463
P 058 10058593
P 05C 00209463
P 060 00258593
P 064 0080066F
P 068 00458593
P 06C 40B02E23
P 070 42C02023
# Byte and word loads, byte stores to each lane
P 074 30100683
P 078 30104703
P 07C 30000783
P 080 30002803
P 084 30100823
P 088 302008A3
P 08C 30400923
P 090 303009A3
P 094 31002883
P 098 42D02223
P 09C 42E02423
P 0A0 42F02623
P 0A4 43002823
P 0A8 43102A23
# x0 write, then counters
P 0AC 05A00013
P 0B0 42002C23
P 0B4 C0202A73
P 0B8 C0002AF3
P 0BC 00100B13
P 0C0 43602E23
P 0C4 43C02B83
P 0C8 C0002C73
P 0CC 415C0CB3
P 0D0 45402023
P 0D4 45902223
P 0D8 00001D37
P 0DC FF7D2E23
P 0E0 0000006F
D 300 C3A5807F
S 400 F 0000005D
S 404 F FFFFFF95
S 408 F 00000001
S 40C F 00000000
S 410 F 0F0F0FF9
S 414 F F0F0F000
S 418 F F0F0F064
S 41C F 00000110
S 420 F 00000068
S 310 1 64646464
S 311 2 F9F9F9F9
S 312 4 95959595
S 313 8 5D5D5D5D
S 424 F FFFFFF80
S 428 F 00000080
S 42C F 0000007F
S 430 F C3A5807F
S 434 F 5D95F964
S 438 F 00000000
S 43C F 00000001
S 440 F 0000002A
S 444 F 0000000F
S FFC F 00000001
E
